/* common/mpuPkg.sv */
package mpuPkg;

`include "mpu_defs.svh"

	// Thread ID
	typedef logic [`WIDTH_ID-1:0] id_t;

	// Address or length in words, one extra bit to hold a full-memory count
	typedef logic [`WIDTH_THREAD_MEM:0] t_address_t;

	// Instruction word
	typedef logic [`WIDTH_INSTR-1:0] instr_t;

	// Lookup answer to the dispatch unit
	typedef struct packed {
		logic		hit;		// Thread ID found
		t_address_t	address;	// Base address of the program
		t_address_t	length;		// Program length in words
	} lookup_t;

	// Store side FSM
	typedef enum logic {
		FSM_MAPMAN_ST_INIT,		// Settling cycle after reset or an ack
		FSM_MAPMAN_ST_RUN		// Ready to take a store
	} fsm_mapman_st;

	// Lookup side FSM
	typedef enum logic {
		FSM_MAPMAN_LD_INIT,		// Idle
		FSM_MAPMAN_LD_RUN		// Ack cycle
	} fsm_mapman_ld;

endpackage

/* common/mpu_defs.svh */
`ifndef MPU_DEFS_SVH
`define MPU_DEFS_SVH

// Thread map table
`define SIZE_TAB_MAPMAN		8		// Slots, power of two
`define WIDTH_TAB_MAPMAN	3		// Slot index bits

// Instruction memory
`define SIZE_THREAD_MEM		256		// Depth in words
`define WIDTH_THREAD_MEM	8		// Word address bits

// Thread ID
`define WIDTH_ID			4

// Instruction word
`define WIDTH_INSTR			32

`endif

/* filelist.f */
+incdir+common
common/mpuPkg.sv
mapMan/ringBuffCtrl.sv
mapMan/mapMan.sv
src/threadMem.sv
src/threadMemTop.sv
verif/threadMemTb.sv

/* mapMan/mapMan.sv */
`timescale 1ns/100ps

`include "mpu_defs.svh"

module mapMan
	import mpuPkg::*;
(
	input	logic		clock,
	input	logic		reset,
	input	logic		ReqSt,			// Store request from the loader
	input	id_t		ThreadIdSt,
	input	t_address_t	LengthSt,		// Program length in words
	output	logic		AckSt,
	input	logic		ReqLookup,		// Lookup pulse from dispatch
	input	id_t		ThreadIdLd,
	output	logic		AckLookup,
	output	lookup_t	ThreadInfo,
	output	t_address_t	UsedSize,
	output	logic		Full
);

	// Slot table
	logic [`SIZE_TAB_MAPMAN-1:0]	tabValid;
	id_t							tabId [`SIZE_TAB_MAPMAN];
	t_address_t						tabAddr [`SIZE_TAB_MAPMAN];
	t_address_t						tabLen [`SIZE_TAB_MAPMAN];

	logic							freeFound;
	logic [`WIDTH_TAB_MAPMAN-1:0]	freeSlot;
	logic							matchFound;
	logic [`WIDTH_TAB_MAPMAN-1:0]	matchSlot;
	logic							dupId;

	fsm_mapman_st					stState;
	fsm_mapman_ld					ldState;

	logic							lookAccept;
	logic							release_;
	lookup_t						lookInfo;

	t_address_t						writePtr;
	t_address_t						freeSize;

	// Lowest free slot and lowest matching slot
	always_comb begin
		freeFound	= 1'b0;
		freeSlot	= '0;
		matchFound	= 1'b0;
		matchSlot	= '0;
		for (int i = `SIZE_TAB_MAPMAN - 1; i >= 0; i--) begin
			if (!tabValid[i]) begin
				freeFound	= 1'b1;
				freeSlot	= `WIDTH_TAB_MAPMAN'(i);
			end
			if (tabValid[i] && tabId[i] == ThreadIdLd) begin
				matchFound	= 1'b1;
				matchSlot	= `WIDTH_TAB_MAPMAN'(i);
			end
		end
	end

	// Any two live slots sharing a thread ID
	always_comb begin
		dupId = 1'b0;
		for (int i = 0; i < `SIZE_TAB_MAPMAN; i++) begin
			for (int j = i + 1; j < `SIZE_TAB_MAPMAN; j++) begin
				if (tabValid[i] && tabValid[j] && tabId[i] == tabId[j])
					dupId = 1'b1;
			end
		end
	end

	assign AckSt = ReqSt && stState == FSM_MAPMAN_ST_RUN && freeFound
		&& LengthSt != '0 && LengthSt <= freeSize;

	assign lookAccept	= ReqLookup && ldState == FSM_MAPMAN_LD_INIT;
	assign release_		= lookAccept && matchFound;		// Frees slot on the ack edge

	assign AckLookup	= ldState == FSM_MAPMAN_LD_RUN;
	assign ThreadInfo	= lookInfo;
	assign Full			= (&tabValid) || UsedSize == t_address_t'(`SIZE_THREAD_MEM);

	always_ff @(posedge clock) begin
		if (reset) begin
			stState <= FSM_MAPMAN_ST_INIT;
		end else begin
			case (stState)
				FSM_MAPMAN_ST_INIT: stState <= FSM_MAPMAN_ST_RUN;
				FSM_MAPMAN_ST_RUN: if (AckSt) stState <= FSM_MAPMAN_ST_INIT;
				default: stState <= FSM_MAPMAN_ST_INIT;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ldState <= FSM_MAPMAN_LD_INIT;
		end else begin
			case (ldState)
				FSM_MAPMAN_LD_INIT: if (ReqLookup) ldState <= FSM_MAPMAN_LD_RUN;
				FSM_MAPMAN_LD_RUN: ldState <= FSM_MAPMAN_LD_INIT;	// Requests here are dropped
				default: ldState <= FSM_MAPMAN_LD_INIT;
			endcase
		end
	end

	// Store and release never hit the same slot
	always_ff @(posedge clock) begin
		if (reset) begin
			tabValid <= '0;
		end else begin
			if (AckSt)
				tabValid[freeSlot] <= 1'b1;
			if (release_)
				tabValid[matchSlot] <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (AckSt) begin
			tabId[freeSlot]		<= ThreadIdSt;
			tabAddr[freeSlot]	<= writePtr;	// Program starts at ring head
			tabLen[freeSlot]	<= LengthSt;
		end
	end

	// Result captured on the release edge
	always_ff @(posedge clock) begin
		if (lookAccept) begin
			lookInfo.hit		<= matchFound;
			lookInfo.address	<= matchFound ? tabAddr[matchSlot] : '0;
			lookInfo.length		<= matchFound ? tabLen[matchSlot] : '0;
		end
	end

	ringBuffCtrl ringBuffCtrl_i (
		.clock		(clock),
		.reset		(reset),
		.Alloc		(AckSt),
		.AllocLen	(LengthSt),
		.Release	(release_),
		.ReleaseLen	(tabLen[matchSlot]),
		.WritePtr	(writePtr),
		.UsedSize	(UsedSize),
		.FreeSize	(freeSize)
	);

	noZeroStore: assert property (@(posedge clock) disable iff (reset)
		AckSt |-> LengthSt != '0);

	lookupLatency: assert property (@(posedge clock) disable iff (reset)
		AckLookup |-> $past(ReqLookup));

	uniqueId: assert property (@(posedge clock) disable iff (reset) !dupId);

endmodule

/* mapMan/ringBuffCtrl.sv */
`timescale 1ns/100ps

`include "mpu_defs.svh"

module ringBuffCtrl
	import mpuPkg::*;
(
	input	logic		clock,
	input	logic		reset,
	input	logic		Alloc,
	input	t_address_t	AllocLen,
	input	logic		Release,
	input	t_address_t	ReleaseLen,
	output	t_address_t	WritePtr,
	output	t_address_t	UsedSize,
	output	t_address_t	FreeSize
);

	t_address_t					writeSum;
	logic [`WIDTH_THREAD_MEM+1:0]	usedNext;	// Wide enough to show under/overflow

	assign writeSum	= WritePtr + AllocLen;

	// Net change when alloc and release share an edge
	assign usedNext = {1'b0, UsedSize}
		+ (Alloc ? {1'b0, AllocLen} : '0)
		- (Release ? {1'b0, ReleaseLen} : '0);

	assign FreeSize = t_address_t'(`SIZE_THREAD_MEM) - UsedSize;

	always_ff @(posedge clock) begin
		if (reset) begin
			WritePtr	<= '0;
			UsedSize	<= '0;
		end else begin
			if (Alloc)
				WritePtr <= {1'b0, writeSum[`WIDTH_THREAD_MEM-1:0]};	// Wrap at depth
			UsedSize <= usedNext[`WIDTH_THREAD_MEM:0];
		end
	end

	occupancyRange: assert property (@(posedge clock) disable iff (reset)
		usedNext <= `SIZE_THREAD_MEM);

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module threadMemTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VthreadMemTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Simulation PASSED" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* src/threadMem.sv */
`timescale 1ns/100ps

`include "mpu_defs.svh"

module threadMem
	import mpuPkg::*;
(
	input	logic		clock,
	input	logic		WordWe,		// Loader write strobe
	input	t_address_t	WordAddr,
	input	instr_t		WordData,
	input	t_address_t	FetchAddr,
	output	instr_t		FetchData	// One cycle after FetchAddr
);

	instr_t							mem [`SIZE_THREAD_MEM];
	logic [`WIDTH_THREAD_MEM-1:0]	wrIndex;
	logic [`WIDTH_THREAD_MEM-1:0]	rdIndex;

	// Top address bit dropped, so a wrapped program stays contiguous
	assign wrIndex = WordAddr[`WIDTH_THREAD_MEM-1:0];
	assign rdIndex = FetchAddr[`WIDTH_THREAD_MEM-1:0];

	always_ff @(posedge clock) begin
		if (WordWe)
			mem[wrIndex] <= WordData;
	end

	// Registered fetch port
	always_ff @(posedge clock) begin
		FetchData <= mem[rdIndex];
	end

endmodule

/* src/threadMemTop.sv */
`timescale 1ns/100ps

module threadMemTop
	import mpuPkg::*;
(
	input	logic		clock,
	input	logic		reset,

	// Loader store request
	input	logic		ReqSt,
	input	id_t		ThreadIdSt,
	input	t_address_t	LengthSt,
	output	logic		AckSt,

	// Dispatch lookup
	input	logic		ReqLookup,
	input	id_t		ThreadIdLd,
	output	logic		AckLookup,
	output	lookup_t	ThreadInfo,

	output	t_address_t	UsedSize,
	output	logic		Full,

	// Loader word writes
	input	logic		WordWe,
	input	t_address_t	WordAddr,
	input	instr_t		WordData,

	// Dispatch fetch
	input	t_address_t	FetchAddr,
	output	instr_t		FetchData
);

	mapMan mapMan_i (
		.clock		(clock),
		.reset		(reset),
		.ReqSt		(ReqSt),
		.ThreadIdSt	(ThreadIdSt),
		.LengthSt	(LengthSt),
		.AckSt		(AckSt),
		.ReqLookup	(ReqLookup),
		.ThreadIdLd	(ThreadIdLd),
		.AckLookup	(AckLookup),
		.ThreadInfo	(ThreadInfo),
		.UsedSize	(UsedSize),
		.Full		(Full)
	);

	threadMem threadMem_i (
		.clock		(clock),
		.WordWe		(WordWe),
		.WordAddr	(WordAddr),
		.WordData	(WordData),
		.FetchAddr	(FetchAddr),
		.FetchData	(FetchData)
	);

endmodule

/* verif/threadMemTb.sv */
`timescale 1ns/100ps

`include "mpu_defs.svh"

module threadMemTb
	import mpuPkg::*;
();

	localparam int CLOCK_PERIOD	= 100;
	localparam int WAIT_LIMIT	= 40;	// Cycles before a handshake counts as lost
	// Cycle budget of reset and the six tests
	localparam int TEST_CYCLES	= 8 + 20 + 120 + 20 + 40 + 140 + 80;

	logic		clock;
	logic		reset;
	logic		ReqSt;
	id_t		ThreadIdSt;
	t_address_t	LengthSt;
	logic		AckSt;
	logic		ReqLookup;
	id_t		ThreadIdLd;
	logic		AckLookup;
	lookup_t	ThreadInfo;
	t_address_t	UsedSize;
	logic		Full;
	logic		WordWe;
	t_address_t	WordAddr;
	instr_t		WordData;
	t_address_t	FetchAddr;
	instr_t		FetchData;

	// Reference model of the programs in store order
	id_t		progId [$];
	t_address_t	progAddr [$];
	t_address_t	progLen [$];
	t_address_t	modelPtr = '0;
	int			modelUsed = 0;

	int			seed = 32'h2594;
	int			errorCount = 0;
	int			checkCount = 0;
	int			testCount = 0;

	threadMemTop threadMemTop_i (.*);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(TEST_CYCLES * 2 * CLOCK_PERIOD);
		$display("Watchdog timeout, the tests did not finish in time");
		$display("Simulation FAILED");
		$finish;
	end

	function automatic logic [31:0] nextRandom();
		return $random(seed);
	endfunction

	function automatic t_address_t randomLen(input int minLen, input int mask);
		logic [31:0] r;
		r = nextRandom();
		return t_address_t'(minLen + int'(r & mask));
	endfunction

	// Index of a live program in the model or -1 if absent
	function automatic int findProg(input id_t id);
		findProg = -1;
		for (int i = 0; i < progId.size(); i++)
			if (progId[i] == id && findProg < 0)
				findProg = i;
	endfunction

	task automatic expectEq(input string what, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		assert (got === exp) else begin
			$display("Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
			errorCount++;
		end
	endtask

	task automatic endTest(input string name, input int errorsAtStart);
		testCount++;
		$display("Test %s finished with %0d errors", name, errorCount - errorsAtStart);
	endtask

	task automatic pickId(output id_t id);
		logic [31:0] r;
		do begin
			r = nextRandom();
			id = r[`WIDTH_ID-1:0];
		end while (findProg(id) >= 0);
	endtask

	// Entered and left on a falling edge
	task automatic storeProgram(input id_t id, input t_address_t len);
		int waitCycles;
		logic acked;
		waitCycles = 0;
		acked = 1'b0;
		ReqSt = 1'b1;
		ThreadIdSt = id;
		LengthSt = len;
		while (!acked && waitCycles < WAIT_LIMIT) begin
			#(CLOCK_PERIOD / 4);
			acked = AckSt;	// Sampled well before the rising edge
			@(negedge clock);
			waitCycles++;
		end
		ReqSt = 1'b0;
		if (!acked) begin
			$display("Store of thread %0d was never acknowledged", id);
			errorCount++;
			return;
		end
		progId.push_back(id);
		progAddr.push_back(modelPtr);
		progLen.push_back(len);
		modelUsed = modelUsed + int'(len);
		modelPtr = t_address_t'((int'(modelPtr) + int'(len)) % `SIZE_THREAD_MEM);
		expectEq("UsedSize after store", 32'(UsedSize), 32'(modelUsed));
	endtask

	task automatic storeNew(input int minLen, input int mask);
		id_t id;
		pickId(id);
		storeProgram(id, randomLen(minLen, mask));
	endtask

	// Holds a store that must not be acknowledged and leaves ReqSt high
	task automatic expectStall(input id_t id, input t_address_t len, input int cycles);
		ReqSt = 1'b1;
		ThreadIdSt = id;
		LengthSt = len;
		repeat (cycles) begin
			#(CLOCK_PERIOD / 4);
			expectEq("AckSt while stalled", 32'(AckSt), 32'd0);
			@(negedge clock);
		end
	endtask

	task automatic lookupThread(input id_t id);
		int idx;
		int waitCycles;
		idx = findProg(id);
		while (AckLookup)	// Request in the ack cycle would be dropped
			@(negedge clock);
		ReqLookup = 1'b1;
		ThreadIdLd = id;
		waitCycles = 0;
		do begin
			@(negedge clock);
			ReqLookup = 1'b0;
			waitCycles++;
		end while (!AckLookup && waitCycles < WAIT_LIMIT);
		if (!AckLookup) begin
			$display("Lookup of thread %0d was never answered", id);
			errorCount++;
			return;
		end
		expectEq("lookup latency", 32'(waitCycles), 32'd1);
		expectEq("ThreadInfo.hit", 32'(ThreadInfo.hit), 32'(idx >= 0));
		if (idx >= 0) begin
			expectEq("ThreadInfo.address", 32'(ThreadInfo.address), 32'(progAddr[idx]));
			expectEq("ThreadInfo.length", 32'(ThreadInfo.length), 32'(progLen[idx]));
			modelUsed = modelUsed - int'(progLen[idx]);
			progId.delete(idx);
			progAddr.delete(idx);
			progLen.delete(idx);
		end
		expectEq("UsedSize after lookup", 32'(UsedSize), 32'(modelUsed));
	endtask

	// Releases everything oldest first as the ring requires
	task automatic drainAll();
		while (progId.size() > 0)
			lookupThread(progId[0]);
	endtask

	task automatic checkReset();
		int errorsAtStart;
		id_t firstId;
		t_address_t firstLen;
		errorsAtStart = errorCount;
		expectEq("AckLookup after reset", 32'(AckLookup), 32'd0);
		expectEq("Full after reset", 32'(Full), 32'd0);
		expectEq("UsedSize after reset", 32'(UsedSize), 32'd0);
		pickId(firstId);
		firstLen = randomLen(1, 15);
		expectStall(firstId, firstLen, 1);	// Store FSM still in INIT
		storeProgram(firstId, firstLen);
		drainAll();	// Model expects base address 0
		endTest("checkReset", errorsAtStart);
	endtask

	task automatic storeAndFind();
		int errorsAtStart;
		errorsAtStart = errorCount;
		for (int round = 0; round < 3; round++) begin
			for (int i = 0; i < 4; i++)
				storeNew(32, 31);	// At most 252 words live and 12 stores wrap the ring
			drainAll();
		end
		endTest("storeAndFind", errorsAtStart);
	endtask

	task automatic missLookup();
		int errorsAtStart;
		id_t absentId;
		errorsAtStart = errorCount;
		storeNew(1, 31);
		pickId(absentId);
		lookupThread(absentId);
		drainAll();
		endTest("missLookup", errorsAtStart);
	endtask

	task automatic releaseInOrder();
		int errorsAtStart;
		id_t firstId;
		errorsAtStart = errorCount;
		for (int i = 0; i < 3; i++)
			storeNew(8, 15);
		firstId = progId[0];
		drainAll();
		lookupThread(firstId);	// Freed ID must miss now
		endTest("releaseInOrder", errorsAtStart);
	endtask

	task automatic backPressure();
		int errorsAtStart;
		id_t waitingId;
		errorsAtStart = errorCount;
		for (int i = 0; i < `SIZE_TAB_MAPMAN; i++)
			storeNew(4, 15);
		expectEq("Full with all slots used", 32'(Full), 32'd1);
		pickId(waitingId);
		expectStall(waitingId, 9'd20, 4);
		lookupThread(progId[0]);
		expectEq("Full after a release", 32'(Full), 32'd0);
		storeProgram(waitingId, 9'd20);
		drainAll();

		// Only 56 words left for 80 requested
		storeNew(100, 0);
		storeNew(100, 0);
		pickId(waitingId);
		expectStall(waitingId, 9'd80, 4);
		lookupThread(progId[0]);
		storeProgram(waitingId, 9'd80);
		drainAll();
		endTest("backPressure", errorsAtStart);
	endtask

	task automatic wordReadback();
		int errorsAtStart;
		t_address_t base;
		instr_t words [12];
		errorsAtStart = errorCount;
		if (modelPtr != 9'd250) begin
			storeNew((250 - int'(modelPtr) + `SIZE_THREAD_MEM) % `SIZE_THREAD_MEM, 0);
			drainAll();
		end
		base = modelPtr;
		storeNew(12, 0);	// Runs from 250 through 5
		for (int k = 0; k < 12; k++) begin
			words[k] = nextRandom();
			WordWe = 1'b1;
			WordAddr = base + t_address_t'(k);
			WordData = words[k];
			@(negedge clock);
		end
		WordWe = 1'b0;
		for (int k = 0; k < 12; k++) begin
			FetchAddr = base + t_address_t'(k);
			@(negedge clock);
			expectEq("FetchData", FetchData, words[k]);
		end
		drainAll();
		endTest("wordReadback", errorsAtStart);
	endtask

	initial begin
		reset = 1'b1;
		ReqSt = 1'b0;
		ThreadIdSt = '0;
		LengthSt = '0;
		ReqLookup = 1'b0;
		ThreadIdLd = '0;
		WordWe = 1'b0;
		WordAddr = '0;
		WordData = '0;
		FetchAddr = '0;
		repeat (8) @(negedge clock);
		reset = 1'b0;
		checkReset();
		storeAndFind();
		missLookup();
		releaseInOrder();
		backPressure();
		wordReadback();
		$display("Tests run: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
